// File: filelist.f
+incdir+src
src/alu_pkg.sv
src/ex_pkg.sv
src/alu.sv
src/csr_wdata_unit.sv
src/ex_stage.sv
verif/ex_stage_tb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/ex_stage_tb.sv
/*
 * execute stage testbench
 * random payloads under random back-pressure, checked against a reference model
 */

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_stage_tb;

	import alu_pkg::*;
	import ex_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TXN    = 1500;
	localparam logic [31:0] SEED = 32'h4c634805;

	typedef struct packed {
		logic [`DATA_LEN-1:0] alu_result;
		logic [`DATA_LEN-1:0] csr_wdata;
		logic                 csr_wen;
		logic                 fwd_wen;
		logic                 csr_fwd_wen;
	} exp_t;

	logic clock;
	logic reset;
	logic ds_to_ex_valid_i, es_allowin_o, es_valid_o, es_to_lsu_valid_o, lsu_allowin_i;
	logic [`DATA_LEN-1:0] reg1_i, reg2_i, pc_i, imm_i, csr_rdata_i;
	alu_op_t alu_op_i;
	src1_sel_t src1_sel_i;
	src2_sel_t src2_sel_i;
	csr_op_t csr_op_i, csr_op_o;
	logic [`CSR_ADDR_LEN-1:0] csr_waddr_i, csr_waddr_o, csr_fwd_addr_o;
	logic wd_i, wd_o, ebreak_i, ebreak_o, mem_wen_o, csr_wen_o, fwd_wen_o, csr_fwd_wen_o;
	logic [`REG_IDX_LEN-1:0] wreg_i, wreg_o, fwd_wreg_o;
	load_type_t load_type_i, load_type_o;
	store_type_t store_type_i, store_type_o;
	logic [`DATA_LEN-1:0] alu_result_o, mem_wdata_o, pc_o, csr_wdata_o;
	logic [`DATA_LEN-1:0] fwd_data_o, csr_fwd_data_o;

	int errors = 0;
	int checks = 0;
	logic model_valid = 1'b0;
	logic last_allowin = 1'b1;
	logic [7:0] sweep_idx = 8'd0;

	ex_stage ex_stage_i (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// expected results straight from the ISA rules
	function automatic exp_t ref_exec(input logic [3:0] op, input logic [1:0] s1, s2,
			input logic [2:0] cop, input logic [31:0] r1, r2, pc, imm, csr,
			input logic valid, wd, input logic [4:0] wreg);
		exp_t e;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] sh;
		a = (s1 == SRC1_REG1) ? r1 : (s1 == SRC1_PC) ? pc : (s1 == SRC1_CSR) ? csr : 32'h0;
		b = (s2 == SRC2_REG2) ? r2 : (s2 == SRC2_IMM) ? imm : (s2 == SRC2_FOUR) ? 32'd4 : 32'h0;
		sh = b[4:0];
		case (op)
			ALU_ADD:  e.alu_result = a + b;
			ALU_SUB:  e.alu_result = a + ~b + 32'd1;
			ALU_XOR:  e.alu_result = a ^ b;
			ALU_OR:   e.alu_result = a | b;
			ALU_AND:  e.alu_result = a & b;
			ALU_SRL:  e.alu_result = a >> sh;
			// sign fill for the vacated upper bits
			ALU_SRA:  e.alu_result = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			ALU_SLL:  e.alu_result = a << sh;
			ALU_SLTU: e.alu_result = {31'b0, a < b};
			ALU_SLT:  e.alu_result = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			default:  e.alu_result = 32'h0;
		endcase
		e.csr_wen = (cop == CSR_CSRRW) || (cop == CSR_CSRRS) || (cop == CSR_ECALL);
		e.csr_wdata = (cop == CSR_CSRRW) ? r1 : (cop == CSR_CSRRS) ? (r1 | csr) :
			(cop == CSR_ECALL) ? pc : 32'h0;
		e.fwd_wen = valid && wd && (wreg != 5'd0);
		e.csr_fwd_wen = valid && e.csr_wen;
		return e;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	// edge values mixed with random ones
	function automatic logic [31:0] pick_operand();
		logic [31:0] r;
		r = $urandom();
		case (r[2:0])
			3'd0: return 32'h0;
			3'd1: return 32'hffff_ffff;
			3'd2: return 32'h8000_0000;
			3'd3: return 32'd31;
			3'd4: return 32'h7fff_ffff;
			default: return $urandom();
		endcase
	endfunction

	// the decode register loads a new instruction while op and selects sweep all pairs
	task automatic drive_payload();
		logic [31:0] r;
		r = $urandom();
		alu_op_i = alu_op_t'(sweep_idx[3:0]);
		src1_sel_i = src1_sel_t'(sweep_idx[5:4]);
		src2_sel_i = src2_sel_t'(sweep_idx[7:6]);
		sweep_idx = sweep_idx + 8'd1;
		reg1_i = pick_operand();
		reg2_i = pick_operand();
		imm_i = pick_operand();
		csr_rdata_i = pick_operand();
		pc_i = $urandom() & 32'hffff_fffc;
		csr_op_i = csr_op_t'(r[2:0]);
		load_type_i = load_type_t'(r[5:3]);
		store_type_i = store_type_t'(r[7:6]);
		wd_i = r[8];
		wreg_i = (r[11:9] == 3'd0) ? 5'd0 : r[16:12];
		ebreak_i = (r[19:17] == 3'd0);
		csr_waddr_i = r[31:20];
	endtask

	task automatic check_outputs();
		exp_t e;
		e = ref_exec(alu_op_i, src1_sel_i, src2_sel_i, csr_op_i, reg1_i, reg2_i, pc_i,
			imm_i, csr_rdata_i, model_valid, wd_i, wreg_i);
		check_field("es_valid", 32'(model_valid), 32'(es_valid_o));
		check_field("es_to_lsu_valid", 32'(model_valid), 32'(es_to_lsu_valid_o));
		check_field("es_allowin", 32'(!model_valid || lsu_allowin_i), 32'(es_allowin_o));
		check_field("alu_result", e.alu_result, alu_result_o);
		check_field("fwd_data", e.alu_result, fwd_data_o);
		check_field("csr_wdata", e.csr_wdata, csr_wdata_o);
		check_field("csr_fwd_data", e.csr_wdata, csr_fwd_data_o);
		check_field("csr_wen", 32'(e.csr_wen), 32'(csr_wen_o));
		check_field("csr_fwd_wen", 32'(e.csr_fwd_wen), 32'(csr_fwd_wen_o));
		check_field("fwd_wen", 32'(e.fwd_wen), 32'(fwd_wen_o));
		check_field("mem_wen", 32'(store_type_i != 2'd0), 32'(mem_wen_o));
		check_field("mem_wdata", reg2_i, mem_wdata_o);
		check_field("load_type", 32'(load_type_i), 32'(load_type_o));
		check_field("store_type", 32'(store_type_i), 32'(store_type_o));
		check_field("wd", 32'(wd_i), 32'(wd_o));
		check_field("wreg", 32'(wreg_i), 32'(wreg_o));
		check_field("fwd_wreg", 32'(wreg_i), 32'(fwd_wreg_o));
		check_field("pc", pc_i, pc_o);
		check_field("ebreak", 32'(ebreak_i), 32'(ebreak_o));
		check_field("csr_waddr", 32'(csr_waddr_i), 32'(csr_waddr_o));
		check_field("csr_fwd_addr", 32'(csr_waddr_i), 32'(csr_fwd_addr_o));
		check_field("csr_op", 32'(csr_op_i), 32'(csr_op_o));
	endtask

	// compare just before each edge and then step the one-bit valid model
	initial begin
		@(posedge clock);
		forever begin
			#(CLK_PERIOD - 1);
			check_outputs();
			last_allowin = es_allowin_o;
			if (reset)
				model_valid = 1'b0;
			else if (!model_valid || lsu_allowin_i)
				model_valid = ds_to_ex_valid_i;
			@(posedge clock);
		end
	end

	initial begin
		#((NUM_TXN + 50) * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d ns", (NUM_TXN + 50) * CLK_PERIOD);
		$display("test failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		drive_payload();
		// a valid instruction that would forward is offered while reset holds
		ds_to_ex_valid_i = 1'b1;
		lsu_allowin_i = 1'b0;
		wd_i = 1'b1;
		wreg_i = 5'd1;
		csr_op_i = CSR_CSRRW;
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		check_field("reset es_valid", 32'h0, 32'(es_valid_o));
		check_field("reset es_to_lsu_valid", 32'h0, 32'(es_to_lsu_valid_o));
		check_field("reset fwd_wen", 32'h0, 32'(fwd_wen_o));
		check_field("reset csr_fwd_wen", 32'h0, 32'(csr_fwd_wen_o));
		check_field("reset es_allowin", 32'h1, 32'(es_allowin_o));
		repeat (NUM_TXN) begin
			@(posedge clock);
			#2;
			lsu_allowin_i = ($urandom_range(0, 9) < 7);
			// decode keeps its payload while the stage is stalled
			if (last_allowin) begin
				ds_to_ex_valid_i = ($urandom_range(0, 3) != 0);
				drive_payload();
			end
		end
		@(posedge clock);
		#2;
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/ex_stage.sv
/*
 * RV32 execute stage
 * valid/allowin control, ALU and CSR write unit side by side,
 * load/store and writeback fields, forwarding back to decode
 */

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_stage (
	input  logic                         clock,
	input  logic                         reset,

	// decode handshake
	input  logic                         ds_to_ex_valid_i,
	output logic                         es_allowin_o,

	// memory stage handshake
	output logic                         es_valid_o,
	output logic                         es_to_lsu_valid_o,
	input  logic                         lsu_allowin_i,

	// payload from the decode register
	input  logic [`DATA_LEN-1:0]         reg1_i,
	input  logic [`DATA_LEN-1:0]         reg2_i,
	input  logic [`DATA_LEN-1:0]         pc_i,
	input  logic [`DATA_LEN-1:0]         imm_i,
	input  logic [`DATA_LEN-1:0]         csr_rdata_i,
	input  alu_pkg::alu_op_t             alu_op_i,
	input  alu_pkg::src1_sel_t           src1_sel_i,
	input  alu_pkg::src2_sel_t           src2_sel_i,
	input  ex_pkg::csr_op_t              csr_op_i,
	input  logic [`CSR_ADDR_LEN-1:0]     csr_waddr_i,
	input  logic                         wd_i,
	input  logic [`REG_IDX_LEN-1:0]      wreg_i,
	input  ex_pkg::load_type_t           load_type_i,
	input  ex_pkg::store_type_t          store_type_i,
	input  logic                         ebreak_i,

	// to memory and writeback
	output logic [`DATA_LEN-1:0]         alu_result_o,
	output logic                         mem_wen_o,
	output logic [`DATA_LEN-1:0]         mem_wdata_o,
	output ex_pkg::load_type_t           load_type_o,
	output ex_pkg::store_type_t          store_type_o,
	output logic                         wd_o,
	output logic [`REG_IDX_LEN-1:0]      wreg_o,
	output logic [`DATA_LEN-1:0]         pc_o,
	output logic                         ebreak_o,
	output logic                         csr_wen_o,
	output logic [`CSR_ADDR_LEN-1:0]     csr_waddr_o,
	output logic [`DATA_LEN-1:0]         csr_wdata_o,
	output ex_pkg::csr_op_t              csr_op_o,

	// forwarding to decode
	output logic                         fwd_wen_o,
	output logic [`REG_IDX_LEN-1:0]      fwd_wreg_o,
	output logic [`DATA_LEN-1:0]         fwd_data_o,
	output logic                         csr_fwd_wen_o,
	output logic [`CSR_ADDR_LEN-1:0]     csr_fwd_addr_o,
	output logic [`DATA_LEN-1:0]         csr_fwd_data_o
);

	import ex_pkg::*;

	logic [`DATA_LEN-1:0] alu_result;
	logic                 csr_wen;
	logic [`DATA_LEN-1:0] csr_wdata;

	// single-cycle stage, free when empty or when memory takes the result
	assign es_allowin_o      = !es_valid_o || lsu_allowin_i;
	assign es_to_lsu_valid_o = es_valid_o;

	always_ff @(posedge clock) begin
		if (reset) begin
			es_valid_o <= 1'b0;
		end else if (es_allowin_o) begin
			es_valid_o <= ds_to_ex_valid_i;
		end
	end

	alu alu_i (
		.src1_sel_i  (src1_sel_i),
		.src2_sel_i  (src2_sel_i),
		.alu_op_i    (alu_op_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.pc_i        (pc_i),
		.imm_i       (imm_i),
		.csr_rdata_i (csr_rdata_i),
		.result_o    (alu_result)
	);

	csr_wdata_unit csr_wdata_unit_i (
		.csr_op_i    (csr_op_i),
		.reg1_i      (reg1_i),
		.pc_i        (pc_i),
		.csr_rdata_i (csr_rdata_i),
		.csr_wen_o   (csr_wen),
		.csr_wdata_o (csr_wdata)
	);

	// store data is always rs2
	assign mem_wen_o    = (store_type_i != STORE_NONE);
	assign mem_wdata_o  = reg2_i;
	assign alu_result_o = alu_result;
	assign load_type_o  = load_type_i;
	assign store_type_o = store_type_i;
	assign wd_o         = wd_i;
	assign wreg_o       = wreg_i;
	assign pc_o         = pc_i;
	assign ebreak_o     = ebreak_i;
	assign csr_wen_o    = csr_wen;
	assign csr_waddr_o  = csr_waddr_i;
	assign csr_wdata_o  = csr_wdata;
	assign csr_op_o     = csr_op_i;

	// x0 never forwards
	assign fwd_wen_o      = es_valid_o && wd_i && (wreg_i != '0);
	assign fwd_wreg_o     = wreg_i;
	assign fwd_data_o     = alu_result;
	assign csr_fwd_wen_o  = es_valid_o && csr_wen;
	assign csr_fwd_addr_o = csr_waddr_i;
	assign csr_fwd_data_o = csr_wdata;

endmodule

`default_nettype wire

// File: src/csr_wdata_unit.sv
/*
 * CSR write unit
 * write data and write enable for CSRRW, CSRRS and ECALL
 */

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module csr_wdata_unit (
	input  ex_pkg::csr_op_t          csr_op_i,
	input  logic [`DATA_LEN-1:0]     reg1_i,
	input  logic [`DATA_LEN-1:0]     pc_i,
	input  logic [`DATA_LEN-1:0]     csr_rdata_i,
	output logic                     csr_wen_o,
	output logic [`DATA_LEN-1:0]     csr_wdata_o
);

	import ex_pkg::*;

	always_comb begin
		csr_wen_o   = 1'b0;
		csr_wdata_o = '0;
		case (csr_op_i)
			CSR_CSRRW: begin
				csr_wen_o   = 1'b1;
				csr_wdata_o = reg1_i;
			end
			// set bits, old value ORed with rs1
			CSR_CSRRS: begin
				csr_wen_o   = 1'b1;
				csr_wdata_o = reg1_i | csr_rdata_i;
			end
			// mepc gets the address of the ecall itself
			CSR_ECALL: begin
				csr_wen_o   = 1'b1;
				csr_wdata_o = pc_i;
			end
			default: begin
				csr_wen_o   = 1'b0;
				csr_wdata_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/alu.sv
/*
 * integer ALU
 * picks two operands and performs one of ten RV32 integer operations
 */

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module alu (
	input  alu_pkg::src1_sel_t       src1_sel_i,
	input  alu_pkg::src2_sel_t       src2_sel_i,
	input  alu_pkg::alu_op_t         alu_op_i,
	input  logic [`DATA_LEN-1:0]     reg1_i,
	input  logic [`DATA_LEN-1:0]     reg2_i,
	input  logic [`DATA_LEN-1:0]     pc_i,
	input  logic [`DATA_LEN-1:0]     imm_i,
	input  logic [`DATA_LEN-1:0]     csr_rdata_i,
	output logic [`DATA_LEN-1:0]     result_o
);

	import alu_pkg::*;

	logic [`DATA_LEN-1:0] src1;
	logic [`DATA_LEN-1:0] src2;
	logic [4:0]           shamt;

	// first operand
	always_comb begin
		src1 = '0;
		case (src1_sel_i)
			SRC1_REG1: src1 = reg1_i;
			SRC1_PC:   src1 = pc_i;
			SRC1_CSR:  src1 = csr_rdata_i;
			default:   src1 = '0;
		endcase
	end

	// second operand, four is the link offset for jal/jalr
	always_comb begin
		src2 = '0;
		case (src2_sel_i)
			SRC2_REG2: src2 = reg2_i;
			SRC2_IMM:  src2 = imm_i;
			SRC2_FOUR: src2 = `DATA_LEN'(4);
			default:   src2 = '0;
		endcase
	end

	// only the low five bits count for RV32 shifts
	assign shamt = src2[4:0];

	always_comb begin
		result_o = '0;
		case (alu_op_i)
			ALU_ADD:  result_o = src1 + src2;
			ALU_SUB:  result_o = src1 - src2;
			ALU_XOR:  result_o = src1 ^ src2;
			ALU_OR:   result_o = src1 | src2;
			ALU_AND:  result_o = src1 & src2;
			ALU_SRL:  result_o = src1 >> shamt;
			ALU_SRA:  result_o = $unsigned($signed(src1) >>> shamt);
			ALU_SLL:  result_o = src1 << shamt;
			ALU_SLTU: result_o = `DATA_LEN'(src1 < src2);
			ALU_SLT:  result_o = `DATA_LEN'($signed(src1) < $signed(src2));
			default:  result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/ex_pkg.sv
/*
 * execute stage package
 * CSR operation codes and load/store type codes
 */

`default_nettype none

package ex_pkg;

	// CSR operations, the remaining codes write nothing
	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_CSRRW = 3'd1,
		CSR_CSRRS = 3'd2,
		CSR_ECALL = 3'd3
	} csr_op_t;

	// load width and sign, zero means no load
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_type_t;

	// store width, zero means no store
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_type_t;

endpackage

`default_nettype wire

// File: src/alu_pkg.sv
/*
 * ALU package
 * operation codes and operand-select codes for the execute stage ALU
 */

`default_nettype none

package alu_pkg;

	// integer operations, unlisted codes give a zero result
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_XOR  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_AND  = 4'd4,
		ALU_SRL  = 4'd5,
		ALU_SRA  = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SLTU = 4'd8,
		ALU_SLT  = 4'd9
	} alu_op_t;

	// first operand source
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_t;

	// second operand source
	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_t;

endpackage

`default_nettype wire

// File: src/ex_params.svh
/*
 * execute stage widths
 * datapath, register index and CSR address sizes shared by the RTL
 */

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath width of the RV32 core
`define DATA_LEN 32

// x0..x31
`define REG_IDX_LEN 5

// CSR address field of the instruction
`define CSR_ADDR_LEN 12

`endif
